/* verilog/res_detect_pkg.sv */
// resolution detection package with counter widths, register map, defaults and register word
package res_detect_pkg;

    localparam int count_w = 13;
    localparam int reg_w = 16;
    localparam int addr_w = 5;

    // anything shorter is treated as noise and never stored
    localparam logic [count_w-1:0] min_count = 13'd32;

    localparam logic [addr_w-1:0] addr_active_samples = 5'd0;
    localparam logic [addr_w-1:0] addr_active_lines = 5'd1;
    localparam logic [addr_w-1:0] addr_total_samples = 5'd2;
    localparam logic [addr_w-1:0] addr_total_lines = 5'd3;
    localparam logic [addr_w-1:0] addr_status = 5'd4;

    localparam logic [reg_w-1:0] default_active_samples = 16'd1920;
    localparam logic [reg_w-1:0] default_active_lines = 16'd1080;

    typedef struct packed {
        logic [reg_w-3:0] reserved;
        logic stable;
        logic res_valid;
    } reg_status_t;

    // one register word, read as a measured count or as the status bits
    typedef union packed {
        logic [reg_w-1:0] count;
        reg_status_t status;
    } reg_word_u;

endpackage

/* verilog/res_detect_if.sv */
// interfaces carrying sync events and timing measurements between the detection blocks
interface timing_if;

    logic valid;
    logic de;
    logic vsync;
    logic hsync;
    logic de_rise;
    logic de_fall;
    logic hsync_rise;
    logic vsync_rise;

    modport producer (
        output valid, de, vsync, hsync, de_rise, de_fall, hsync_rise, vsync_rise
    );

    modport consumer (
        input valid, de, vsync, hsync, de_rise, de_fall, hsync_rise, vsync_rise
    );

endinterface

interface measure_if import res_detect_pkg::*; ();

    logic [count_w-1:0] active_samples;
    logic [count_w-1:0] total_samples;
    logic [count_w-1:0] active_lines;
    logic [count_w-1:0] total_lines;
    logic sample_change;
    logic line_change;
    logic vblank_rise;
    logic vblank_fall;

    modport line_producer (
        output active_lines, total_lines, line_change, vblank_rise, vblank_fall
    );

    // the sample counter holds off during vertical blanking
    modport sample_producer (
        output active_samples, total_samples, sample_change,
        input vblank_rise, vblank_fall
    );

    modport consumer (
        input active_samples, total_samples, active_lines, total_lines,
        input sample_change, line_change, vblank_rise, vblank_fall
    );

endinterface

/* verilog/timing_event_detect.sv */
// sync edge detector producing datavalid-qualified de, hsync and vsync strobes
module timing_event_detect (
    input  logic clk,
    input  logic rst,
    input  logic datavalid,
    input  logic de,
    input  logic hsync,
    input  logic vsync,
    timing_if.producer ev
);

    logic de_q;
    logic hsync_q;
    logic vsync_q;

    // previous levels only move on valid cycles so gaps in the stream are invisible
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            de_q <= 1'b0;
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
        end else if (datavalid) begin
            de_q <= de;
            hsync_q <= hsync;
            vsync_q <= vsync;
        end
    end

    assign ev.valid = datavalid;
    assign ev.de = de;
    assign ev.hsync = hsync;
    assign ev.vsync = vsync;

    assign ev.de_rise = datavalid && de && !de_q;
    assign ev.de_fall = datavalid && !de && de_q;
    assign ev.hsync_rise = datavalid && hsync && !hsync_q;
    assign ev.vsync_rise = datavalid && vsync && !vsync_q;

endmodule

/* verilog/line_tracker.sv */
// line FSM that finds vertical blanking edges and measures active and total lines
module line_tracker import res_detect_pkg::*; (
    input  logic clk,
    input  logic rst,
    timing_if.consumer ev,
    measure_if.line_producer meas
);

    typedef enum logic [1:0] {
        s_idle,
        s_look_for_de,
        s_active_lines,
        s_count_active_line
    } line_state_t;

    line_state_t state;
    line_state_t state_nxt;
    logic [count_w-1:0] line_count;
    logic [count_w-1:0] active_lines_q;
    logic [count_w-1:0] total_lines_q;
    logic line_change_q;
    logic line_start;
    logic vblank_rise;
    logic vblank_fall;

    // a de rise while hsync is still high is not taken as a line start
    assign line_start = ev.de_rise && !ev.hsync;

    always_comb begin
        state_nxt = state;
        vblank_rise = 1'b0;
        vblank_fall = 1'b0;
        case (state)
            s_idle: begin
                if (ev.hsync_rise && !ev.de && !ev.vsync)
                    state_nxt = s_look_for_de;
            end
            s_look_for_de: begin
                if (line_start) begin
                    vblank_fall = 1'b1;
                    state_nxt = s_active_lines;
                end
            end
            s_active_lines: begin
                if (ev.hsync_rise)
                    state_nxt = s_count_active_line;
            end
            s_count_active_line: begin
                // a whole line without de means the active region has ended
                if (ev.hsync_rise) begin
                    vblank_rise = 1'b1;
                    state_nxt = s_look_for_de;
                end else if (line_start) begin
                    state_nxt = s_active_lines;
                end
            end
            default: state_nxt = s_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= s_idle;
            line_count <= '0;
            active_lines_q <= '0;
            total_lines_q <= '0;
            line_change_q <= 1'b0;
        end else if (ev.valid) begin
            state <= state_nxt;
            if (vblank_fall)
                line_count <= '0;
            else if (ev.hsync_rise)
                line_count <= line_count + 1'b1;

            line_change_q <= 1'b0;
            if (vblank_rise && line_count >= min_count && line_count != active_lines_q) begin
                active_lines_q <= line_count;
                line_change_q <= 1'b1;
            end
            if (vblank_fall && line_count >= min_count && line_count != total_lines_q) begin
                total_lines_q <= line_count;
                line_change_q <= 1'b1;
            end
        end
    end

    assign meas.active_lines = active_lines_q;
    assign meas.total_lines = total_lines_q;
    assign meas.line_change = line_change_q;
    assign meas.vblank_rise = vblank_rise;
    assign meas.vblank_fall = vblank_fall;

endmodule

/* verilog/sample_measure.sv */
// sample counter that captures active and total samples per line
module sample_measure import res_detect_pkg::*; (
    input  logic clk,
    input  logic rst,
    timing_if.consumer ev,
    measure_if.sample_producer meas
);

    logic [count_w-1:0] sample_count;
    logic [count_w-1:0] active_samples_q;
    logic [count_w-1:0] total_samples_q;
    logic sample_change_q;
    logic in_blank;
    logic active_hit;
    logic total_hit;

    assign active_hit = ev.de_fall && sample_count >= min_count
                        && sample_count != active_samples_q;
    assign total_hit = ev.de_rise && sample_count >= min_count
                       && sample_count != total_samples_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample_count <= '0;
            active_samples_q <= '0;
            total_samples_q <= '0;
            sample_change_q <= 1'b0;
            in_blank <= 1'b1;
        end else if (ev.valid) begin
            if (meas.vblank_rise)
                in_blank <= 1'b1;
            else if (meas.vblank_fall)
                in_blank <= 1'b0;

            // held at zero over vertical blanking so the first line of a frame
            // never looks like a very long line
            if (ev.de_rise)
                sample_count <= count_w'(1);
            else if (in_blank)
                sample_count <= '0;
            else
                sample_count <= sample_count + 1'b1;

            if (active_hit)
                active_samples_q <= sample_count;
            if (total_hit)
                total_samples_q <= sample_count;
            sample_change_q <= active_hit || total_hit;
        end
    end

    assign meas.active_samples = active_samples_q;
    assign meas.total_samples = total_samples_q;
    assign meas.sample_change = sample_change_q;

endmodule

/* verilog/lock_monitor.sv */
// line-length stability FSM and resolution-valid tracker
module lock_monitor (
    input  logic clk,
    input  logic rst,
    timing_if.consumer ev,
    measure_if.consumer meas,
    output logic stable,
    output logic res_valid
);

    typedef enum logic [2:0] {
        s_unlocked,
        s_first_total,
        s_second_line,
        s_second_total,
        s_stable
    } stable_state_t;

    stable_state_t state;
    stable_state_t state_nxt;
    logic de_rise_q;
    logic de_fall_q;
    logic vblank_fall_q;
    logic dirty;
    logic any_change;
    logic complete;

    assign any_change = meas.sample_change || meas.line_change;
    assign complete = (meas.active_samples != '0) && (meas.total_samples != '0)
                      && (meas.active_lines != '0) && (meas.total_lines != '0);

    // the delayed de edges line up with the change flags of the captures they caused
    always_comb begin
        state_nxt = state;
        if (meas.sample_change) begin
            state_nxt = s_unlocked;
        end else begin
            case (state)
                s_unlocked: if (de_fall_q) state_nxt = s_first_total;
                s_first_total: if (de_rise_q) state_nxt = s_second_line;
                s_second_line: if (de_fall_q) state_nxt = s_second_total;
                s_second_total: if (de_rise_q) state_nxt = s_stable;
                s_stable: state_nxt = s_stable;
                default: state_nxt = s_unlocked;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= s_unlocked;
            de_rise_q <= 1'b0;
            de_fall_q <= 1'b0;
            vblank_fall_q <= 1'b0;
            dirty <= 1'b1;
            res_valid <= 1'b0;
        end else if (ev.valid) begin
            state <= state_nxt;
            de_rise_q <= ev.de_rise;
            de_fall_q <= ev.de_fall;
            vblank_fall_q <= meas.vblank_fall;
            // the total-lines flag from this frame start still belongs to the closing window
            if (vblank_fall_q) begin
                res_valid <= complete && !dirty && !any_change;
                dirty <= 1'b0;
            end else if (any_change) begin
                res_valid <= 1'b0;
                dirty <= 1'b1;
            end
        end
    end

    assign stable = (state == s_stable);

endmodule

/* verilog/register_writer.sv */
// register write FSM for defaults, per-frame measurements and status
module register_writer import res_detect_pkg::*; (
    input  logic clk,
    input  logic rst,
    timing_if.consumer ev,
    measure_if.consumer meas,
    input  logic stable,
    input  logic res_valid,
    input  logic mem_stall,
    output logic mem_write,
    output logic [addr_w-1:0] mem_address,
    output logic [reg_w-1:0] mem_write_data
);

    typedef enum logic [3:0] {
        s_def_active_samples,
        s_def_active_lines,
        s_def_total_samples,
        s_def_status,
        s_wait_first_frame,
        s_wait_event,
        s_wait_capture,
        s_wr_active_samples,
        s_wr_active_lines,
        s_wr_total_samples,
        s_wr_total_lines,
        s_wr_status
    } wr_state_t;

    wr_state_t state;
    wr_state_t state_nxt;
    reg_word_u data_q;
    reg_word_u data_nxt;
    logic end_of_active;
    logic start_of_active;

    assign end_of_active = ev.valid && ev.hsync_rise && meas.vblank_rise;
    assign start_of_active = ev.valid && meas.vblank_fall;

    always_comb begin
        state_nxt = state;
        mem_write = 1'b1;
        mem_address = addr_status;
        case (state)
            s_def_active_samples: begin
                mem_address = addr_active_samples;
                state_nxt = s_def_active_lines;
            end
            s_def_active_lines: begin
                mem_address = addr_active_lines;
                state_nxt = s_def_total_samples;
            end
            s_def_total_samples: begin
                mem_address = addr_total_samples;
                state_nxt = s_def_status;
            end
            s_def_status: begin
                state_nxt = s_wait_first_frame;
            end
            s_wait_first_frame: begin
                mem_write = 1'b0;
                if (start_of_active)
                    state_nxt = s_wait_event;
            end
            s_wait_event: begin
                mem_write = 1'b0;
                if (end_of_active)
                    state_nxt = s_wr_active_samples;
                else if (start_of_active)
                    state_nxt = s_wait_capture;
            end
            // res_valid for the closing frame settles at the end of the next valid cycle
            s_wait_capture: begin
                mem_write = 1'b0;
                if (ev.valid)
                    state_nxt = s_wr_total_lines;
            end
            s_wr_active_samples: begin
                mem_address = addr_active_samples;
                if (!mem_stall)
                    state_nxt = s_wr_active_lines;
            end
            s_wr_active_lines: begin
                mem_address = addr_active_lines;
                if (!mem_stall)
                    state_nxt = s_wr_total_samples;
            end
            s_wr_total_samples: begin
                mem_address = addr_total_samples;
                if (!mem_stall)
                    state_nxt = s_wr_status;
            end
            s_wr_total_lines: begin
                mem_address = addr_total_lines;
                if (!mem_stall)
                    state_nxt = s_wr_status;
            end
            s_wr_status: begin
                if (!mem_stall)
                    state_nxt = s_wait_event;
            end
            default: begin
                mem_write = 1'b0;
                state_nxt = s_wait_event;
            end
        endcase
    end

    // the word is loaded only on entry to a write, so a stalled write keeps its data
    always_comb begin
        data_nxt = data_q;
        if (state_nxt != state) begin
            case (state_nxt)
                s_def_active_lines: data_nxt.count = default_active_lines;
                s_def_total_samples: data_nxt.count = '0;
                s_def_status: data_nxt.status = '0;
                s_wr_active_samples: data_nxt.count = reg_w'(meas.active_samples);
                s_wr_active_lines: data_nxt.count = reg_w'(meas.active_lines);
                s_wr_total_samples: data_nxt.count = reg_w'(meas.total_samples);
                s_wr_total_lines: data_nxt.count = reg_w'(meas.total_lines);
                s_wr_status: begin
                    data_nxt.status.reserved = '0;
                    data_nxt.status.stable = stable;
                    data_nxt.status.res_valid = res_valid;
                end
                default: data_nxt = data_q;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= s_def_active_samples;
            data_q.count <= default_active_samples;
        end else begin
            state <= state_nxt;
            data_q <= data_nxt;
        end
    end

    assign mem_write_data = data_q;

endmodule

/* verilog/resolution_detect.sv */
// video resolution detector top level with register write port and frame pulses
module resolution_detect import res_detect_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic datavalid,
    input  logic de,
    input  logic hsync,
    input  logic vsync,
    input  logic mem_stall,
    output logic mem_write,
    output logic [addr_w-1:0] mem_address,
    output logic [reg_w-1:0] mem_write_data,
    output logic sof,
    output logic sof_locked,
    output logic refclk_div
);

    logic stable;
    logic res_valid;

    timing_if ev ();
    measure_if meas ();

    timing_event_detect timing_event_detect_i (
        .clk(clk),
        .rst(rst),
        .datavalid(datavalid),
        .de(de),
        .hsync(hsync),
        .vsync(vsync),
        .ev(ev)
    );

    line_tracker line_tracker_i (
        .clk(clk),
        .rst(rst),
        .ev(ev),
        .meas(meas)
    );

    sample_measure sample_measure_i (
        .clk(clk),
        .rst(rst),
        .ev(ev),
        .meas(meas)
    );

    lock_monitor lock_monitor_i (
        .clk(clk),
        .rst(rst),
        .ev(ev),
        .meas(meas),
        .stable(stable),
        .res_valid(res_valid)
    );

    register_writer register_writer_i (
        .clk(clk),
        .rst(rst),
        .ev(ev),
        .meas(meas),
        .stable(stable),
        .res_valid(res_valid),
        .mem_stall(mem_stall),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_write_data(mem_write_data)
    );

    // progressive only, so every vsync rise starts a frame
    assign sof = ev.vsync_rise;
    assign refclk_div = ev.hsync_rise;
    assign sof_locked = stable;

endmodule

/* sim/tb_clock_gen.sv */
// testbench clock and reset source with a 20 unit clock period
module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset is held over the first eight rising edges
    initial begin
        rst <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* sim/resolution_detect_sva.sv */
// write port assertions for the resolution detector, bound to the top level
module resolution_detect_sva import res_detect_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic mem_stall,
    input  logic mem_write,
    input  logic [addr_w-1:0] mem_address,
    input  logic [reg_w-1:0] mem_write_data
);

    // a stalled write keeps its request, address and data until it completes
    stall_holds_write: assert property (
        @(posedge clk) disable iff (rst)
        (mem_write && mem_stall) |=>
            (mem_write && $stable(mem_address) && $stable(mem_write_data))
    ) else $error("write request changed while the port was stalled");

    // only the five registers of the map are ever addressed
    address_in_map: assert property (
        @(posedge clk) disable iff (rst)
        mem_address < 5'd5
    ) else $error("write address outside the register map");

endmodule

/* sim/resolution_detect_tb.sv */
// testbench for the resolution detector with random video formats and a register model
module resolution_detect_tb import res_detect_pkg::*; ();

    logic clk;
    logic rst;
    logic datavalid;
    logic de;
    logic hsync;
    logic vsync;
    logic mem_stall;
    logic mem_write;
    logic [addr_w-1:0] mem_address;
    logic [reg_w-1:0] mem_write_data;
    logic sof;
    logic sof_locked;
    logic refclk_div;

    logic [31:0] rng_state;
    logic stall_en;
    int fmt_act_samples;
    int fmt_blank_samples;
    int fmt_act_lines;
    int fmt_blank_lines;
    int sof_seen;
    int refclk_seen;
    logic [reg_w-1:0] model_mem [0:31];
    logic [reg_w-1:0] last_status;
    logic [addr_w+reg_w-1:0] default_log [$];

    tb_clock_gen tb_clock_gen_i (
        .clk(clk),
        .rst(rst)
    );

    resolution_detect resolution_detect_i (
        .clk(clk),
        .rst(rst),
        .datavalid(datavalid),
        .de(de),
        .hsync(hsync),
        .vsync(vsync),
        .mem_stall(mem_stall),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_write_data(mem_write_data),
        .sof(sof),
        .sof_locked(sof_locked),
        .refclk_div(refclk_div)
    );

    bind resolution_detect resolution_detect_sva resolution_detect_sva_i (
        .clk(clk),
        .rst(rst),
        .mem_stall(mem_stall),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_write_data(mem_write_data)
    );

    // register model, a write completes when the port is not stalled
    always @(negedge clk) begin
        if (!rst && mem_write && !mem_stall) begin
            model_mem[mem_address] = mem_write_data;
            if (mem_address == addr_status)
                last_status = mem_write_data;
            if (default_log.size() < 4)
                default_log.push_back({mem_address, mem_write_data});
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    task automatic stop_on_failure();
        $display("TB FAILED");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        stop_on_failure();
    endtask

    task automatic check_value(input string name, input logic [reg_w-1:0] got,
                               input logic [reg_w-1:0] expected);
        assert (got === expected) else begin
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d",
                     $time, name, got, expected);
            stop_on_failure();
        end
    endtask

    task automatic check_default_write(input int index, input logic [addr_w-1:0] addr,
                                       input logic [reg_w-1:0] data);
        logic [addr_w+reg_w-1:0] entry;
        entry = default_log[index];
        check_value("default write mem_address", 16'(entry[addr_w+reg_w-1:reg_w]), 16'(addr));
        check_value("default write mem_write_data", entry[reg_w-1:0], data);
    endtask

    task automatic pick_format();
        logic [31:0] r;
        draw_random(r);
        fmt_act_samples = 40 + int'(r % 32'd41);
        draw_random(r);
        fmt_blank_samples = 8 + int'(r % 32'd13);
        draw_random(r);
        fmt_act_lines = 34 + int'(r % 32'd17);
        draw_random(r);
        fmt_blank_lines = 3 + int'(r % 32'd6);
    endtask

    // one sample, preceded by up to eight cycles without datavalid
    task automatic send_sample(input logic de_val, input logic hsync_val, input logic vsync_val);
        logic [31:0] r;
        int drops;
        logic sent;
        drops = 0;
        sent = 1'b0;
        while (!sent) begin
            draw_random(r);
            @(posedge clk);
            mem_stall <= stall_en && (r[1:0] == 2'b00);
            if (r[3:2] == 2'b00 && drops < 8) begin
                datavalid <= 1'b0;
                drops++;
            end else begin
                datavalid <= 1'b1;
                de <= de_val;
                hsync <= hsync_val;
                vsync <= vsync_val;
                sent = 1'b1;
            end
            @(negedge clk);
            if (sof)
                sof_seen++;
            if (refclk_div)
                refclk_seen++;
        end
    endtask

    // blank lines with vsync on the first two, then the active lines
    task automatic send_frame();
        int line_len;
        int lines;
        logic cur_de;
        logic cur_hsync;
        logic cur_vsync;
        line_len = fmt_act_samples + fmt_blank_samples;
        lines = fmt_blank_lines + fmt_act_lines;
        sof_seen = 0;
        refclk_seen = 0;
        for (int ln = 0; ln < lines; ln++) begin
            for (int px = 0; px < line_len; px++) begin
                cur_vsync = (ln < 2);
                cur_de = (ln >= fmt_blank_lines) && (px < fmt_act_samples);
                cur_hsync = (px >= fmt_act_samples + 2) && (px < fmt_act_samples + 6);
                send_sample(cur_de, cur_hsync, cur_vsync);
            end
        end
        check_value("sof pulses per frame", 16'(sof_seen), 16'd1);
        check_value("refclk_div pulses per frame", 16'(refclk_seen), 16'(lines));
    endtask

    // status word has stable in bit 1 and res_valid in bit 0
    task automatic check_registers();
        check_value("active samples register", model_mem[addr_active_samples],
                    16'(fmt_act_samples));
        check_value("active lines register", model_mem[addr_active_lines],
                    16'(fmt_act_lines));
        check_value("total samples register", model_mem[addr_total_samples],
                    16'(fmt_act_samples + fmt_blank_samples));
        check_value("total lines register", model_mem[addr_total_lines],
                    16'(fmt_act_lines + fmt_blank_lines));
        check_value("status register", last_status, 16'h0003);
        check_value("sof_locked", 16'(sof_locked), 16'd1);
    endtask

    initial begin
        int waited;
        datavalid <= 1'b0;
        de <= 1'b0;
        hsync <= 1'b0;
        vsync <= 1'b0;
        mem_stall <= 1'b0;
        stall_en = 1'b0;
        rng_state = 32'h156;
        last_status = 16'hffff;
        for (int i = 0; i < 32; i++)
            model_mem[i] = {11'h6b5, 5'(i)};

        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 20)
                report_timeout("reset release");
        end while (rst);

        waited = 0;
        while (default_log.size() < 4) begin
            @(posedge clk);
            waited++;
            if (waited > 20)
                report_timeout("the four default register writes");
        end
        @(negedge clk);
        check_value("mem_write after defaults", 16'(mem_write), 16'd0);
        check_default_write(0, addr_active_samples, 16'd1920);
        check_default_write(1, addr_active_lines, 16'd1080);
        check_default_write(2, addr_total_samples, 16'd0);
        check_default_write(3, addr_status, 16'd0);

        // a frame's active region is written out in the blanking of the next frame
        stall_en = 1'b1;
        pick_format();
        repeat (3) send_frame();
        check_registers();

        pick_format();
        repeat (3) send_frame();
        check_registers();

        $display("TB PASSED");
        $finish;
    end

endmodule

/* build.f */
verilog/res_detect_pkg.sv
verilog/res_detect_if.sv
verilog/timing_event_detect.sv
verilog/line_tracker.sv
verilog/sample_measure.sv
verilog/lock_monitor.sv
verilog/register_writer.sv
verilog/resolution_detect.sv
sim/tb_clock_gen.sv
sim/resolution_detect_sva.sv
sim/resolution_detect_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the resolution detector testbench with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module resolution_detect_tb \
    -f build.f -o sim_resolution_detect &&
./obj_dir/sim_resolution_detect || { echo "simulation failed"; exit 1; }
